// ==== hdl/pdp8Pkg.sv ====
// PDP-8 core shared definitions
// Word and opcode types, decoded instruction, ALU command,
// memory request and APB bus structs, host register map

package pdp8Pkg;

  typedef logic [11:0] pdpWord;

  // Major opcodes, IR bits 11:9
  typedef enum logic [2:0] {
    opAnd,
    opTad,
    opIsz,
    opDca,
    opJms,
    opJmp,
    opIot,
    opOpr
  } pdpOpcode;

  // Field order follows IR bits 7:0
  typedef struct packed {
    logic cla;
    logic cll;
    logic cma;
    logic cml;
    logic rar;
    logic ral;
    logic bsw;
    logic iac;
  } oprGroup1;

  typedef struct packed {
    logic cla;
    logic sma;
    logic sza;
    logic snl;
    logic invert;
    logic hlt;
  } oprGroup2;

  typedef struct packed {
    pdpOpcode opcode;
    logic     indirect;
    pdpWord   ea;
    logic     isGroup1;
    logic     isGroup2;
    oprGroup1 group1;
    oprGroup2 group2;
  } decodedInstr;

  typedef enum logic [2:0] {
    aluNone,
    aluAndMem,
    aluTadMem,
    aluClearAc,
    aluGroup1Step,
    aluGroup2Clear
  } aluOp;

  typedef struct packed {
    aluOp       op;
    logic [1:0] step;
    pdpWord     operand;
  } aluCmd;

  typedef struct packed {
    pdpWord addr;
    pdpWord wdata;
    logic   we;
    logic   re;
  } memReq;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [15:0] paddr;
    logic [31:0] pwdata;
  } apbReq;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apbRsp;

  // Host register map
  localparam logic [15:0] ctrlAddr   = 16'h0000;
  localparam logic [15:0] startAddr  = 16'h0004;
  localparam logic [15:0] statusAddr = 16'h0008;
  localparam int          memWindowBit = 14;

endpackage

// ==== hdl/pdp8Decode.sv ====
// PDP-8 instruction decoder
// Splits opcode, resolves page-zero or current-page address
// and unpacks the OPR micro-op bits

`timescale 1ns/10ps

module pdp8Decode (
  input  pdp8Pkg::pdpWord      ir,
  input  pdp8Pkg::pdpWord      pc,
  output pdp8Pkg::decodedInstr instr
);

  logic isMemRef;

  assign isMemRef = (ir[11:9] < 3'd6);

  always_comb begin
    instr = '0;
    instr.opcode = pdp8Pkg::pdpOpcode'(ir[11:9]);

    // Bit 8 selects the OPR group, so only memory references defer
    instr.indirect = isMemRef && ir[8];

    // Page bit picks the page of the instruction
    if (ir[7]) begin
      instr.ea = {pc[11:7], ir[6:0]};
    end else begin
      instr.ea = {5'b00000, ir[6:0]};
    end

    if (instr.opcode == pdp8Pkg::opOpr) begin
      if (!ir[8]) begin
        instr.isGroup1 = 1'b1;
        instr.group1 = pdp8Pkg::oprGroup1'(ir[7:0]);
      end else begin
        instr.isGroup2 = 1'b1;
        // Group 3 words leave every bit clear
        if (!ir[0]) begin
          instr.group2.cla = ir[7];
          instr.group2.sma = ir[6];
          instr.group2.sza = ir[5];
          instr.group2.snl = ir[4];
          instr.group2.invert = ir[3];
          instr.group2.hlt = ir[1];
        end
      end
    end
  end

endmodule

// ==== hdl/pdp8Execute.sv ====
// PDP-8 instruction sequencer
// Holds PC and IR and steps through fetch, defer, operand read,
// write-back and OPR micro-op cycles

`timescale 1ns/10ps

module pdp8Execute (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 start,
  input  pdp8Pkg::pdpWord      startPc,
  input  pdp8Pkg::decodedInstr instr,
  input  pdp8Pkg::pdpWord      memRdata,
  input  logic                 skipTaken,
  input  pdp8Pkg::pdpWord      acValue,
  output pdp8Pkg::pdpWord      ir,
  output pdp8Pkg::pdpWord      pc,
  output pdp8Pkg::memReq       memPort,
  output pdp8Pkg::aluCmd       alu,
  output logic                 running
);

  typedef enum logic [2:0] {
    sIdle,
    sFetch,
    sIr,
    sAddr,
    sDefer,
    sOperand,
    sWrite,
    sStep
  } execState;

  execState        state;
  execState        nextState;
  pdp8Pkg::pdpWord nextPc;
  pdp8Pkg::pdpWord eaReg;
  pdp8Pkg::pdpWord iszWord;
  pdp8Pkg::pdpWord operandAddr;
  logic [1:0]      stepCnt;
  logic            dispatchOp;

  assign running = (state != sIdle);

  // After a defer the pointer word is the operand address
  assign operandAddr = (state == sDefer) ? memRdata : instr.ea;

  always_comb begin
    nextState = state;
    nextPc = pc;
    dispatchOp = 1'b0;
    memPort = '0;
    alu = '0;
    alu.step = stepCnt;
    alu.operand = memRdata;
    case (state)
      sIdle: begin
        if (start) begin
          nextPc = startPc;
          nextState = sFetch;
        end
      end
      sFetch: begin
        memPort.addr = pc;
        memPort.re = 1'b1;
        nextState = sIr;
      end
      sIr: nextState = sAddr;
      sAddr: begin
        if (instr.isGroup1) begin
          alu.op = pdp8Pkg::aluGroup1Step;
          nextState = sStep;
        end else if (instr.isGroup2) begin
          // Skip test sees AC before the CLA of this word
          alu.op = pdp8Pkg::aluGroup2Clear;
          nextPc = pc + (skipTaken ? 12'd2 : 12'd1);
          nextState = instr.group2.hlt ? sIdle : sFetch;
        end else if (instr.opcode == pdp8Pkg::opIot) begin
          nextPc = pc + 12'd1;
          nextState = sFetch;
        end else if (instr.indirect) begin
          memPort.addr = instr.ea;
          memPort.re = 1'b1;
          nextState = sDefer;
        end else begin
          dispatchOp = 1'b1;
        end
      end
      sDefer: dispatchOp = 1'b1;
      sOperand: begin
        if (instr.opcode == pdp8Pkg::opIsz) begin
          nextState = sWrite;
        end else begin
          alu.op = (instr.opcode == pdp8Pkg::opAnd) ? pdp8Pkg::aluAndMem
                                                    : pdp8Pkg::aluTadMem;
          nextPc = pc + 12'd1;
          nextState = sFetch;
        end
      end
      sWrite: begin
        memPort.addr = eaReg;
        memPort.we = 1'b1;
        nextState = sFetch;
        case (instr.opcode)
          pdp8Pkg::opDca: begin
            memPort.wdata = acValue;
            alu.op = pdp8Pkg::aluClearAc;
            nextPc = pc + 12'd1;
          end
          pdp8Pkg::opJms: begin
            memPort.wdata = pc + 12'd1;
            nextPc = eaReg + 12'd1;
          end
          default: begin
            memPort.wdata = iszWord;
            nextPc = pc + ((iszWord == '0) ? 12'd2 : 12'd1);
          end
        endcase
      end
      default: begin
        alu.op = pdp8Pkg::aluGroup1Step;
        if (stepCnt == 2'd3) begin
          nextPc = pc + 12'd1;
          nextState = sFetch;
        end
      end
    endcase

    // Address known, either direct or from the pointer
    if (dispatchOp) begin
      case (instr.opcode)
        pdp8Pkg::opAnd, pdp8Pkg::opTad, pdp8Pkg::opIsz: begin
          memPort.addr = operandAddr;
          memPort.re = 1'b1;
          nextState = sOperand;
        end
        pdp8Pkg::opJmp: begin
          nextPc = operandAddr;
          nextState = sFetch;
        end
        default: nextState = sWrite;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= sIdle;
      pc <= '0;
      ir <= '0;
      stepCnt <= '0;
    end else begin
      state <= nextState;
      pc <= nextPc;
      if (state == sIr) begin
        ir <= memRdata;
      end
      // Wraps to zero after the rotate step
      if (alu.op == pdp8Pkg::aluGroup1Step) begin
        stepCnt <= stepCnt + 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (dispatchOp) begin
      eaReg <= operandAddr;
    end
    if (state == sOperand) begin
      iszWord <= memRdata + 12'd1;
    end
  end

  assert property (@(posedge clk) disable iff (!rstN) !(memPort.re && memPort.we));

endmodule

// ==== hdl/pdp8Result.sv ====
// PDP-8 accumulator and link datapath
// AND and TAD with memory, group-1 micro-ops one step per cycle,
// group-2 skip evaluation

`timescale 1ns/10ps

module pdp8Result (
  input  logic             clk,
  input  logic             rstN,
  input  pdp8Pkg::aluCmd   alu,
  input  pdp8Pkg::oprGroup1 group1,
  input  pdp8Pkg::oprGroup2 group2,
  output pdp8Pkg::pdpWord  ac,
  output logic             link,
  output logic             skipTaken
);

  pdp8Pkg::pdpWord acNext;
  logic            linkNext;
  logic [12:0]     tadSum;
  logic [12:0]     incSum;
  logic [12:0]     linkAc;
  logic            condHit;

  assign tadSum = {1'b0, ac} + {1'b0, alu.operand};
  assign incSum = {1'b0, ac} + 13'd1;

  // Inverted sense skips only when every selected condition fails
  assign condHit = (group2.sma && ac[11]) || (group2.sza && (ac == '0)) || (group2.snl && link);
  assign skipTaken = condHit ^ group2.invert;

  always_comb begin
    acNext = ac;
    linkNext = link;
    linkAc = {link, ac};
    case (alu.op)
      pdp8Pkg::aluAndMem: acNext = ac & alu.operand;
      pdp8Pkg::aluTadMem: begin
        acNext = tadSum[11:0];
        linkNext = link ^ tadSum[12];
      end
      pdp8Pkg::aluClearAc: acNext = '0;
      pdp8Pkg::aluGroup2Clear: begin
        if (group2.cla) begin
          acNext = '0;
        end
      end
      pdp8Pkg::aluGroup1Step: begin
        case (alu.step)
          2'd0: begin
            if (group1.cla) acNext = '0;
            if (group1.cll) linkNext = 1'b0;
          end
          2'd1: begin
            if (group1.cma) acNext = ~ac;
            if (group1.cml) linkNext = ~link;
          end
          2'd2: begin
            if (group1.iac) begin
              acNext = incSum[11:0];
              linkNext = link ^ incSum[12];
            end
          end
          default: begin
            // Rotates go through the link, bsw alone swaps 6-bit halves
            if (group1.ral) begin
              linkAc = group1.bsw ? {linkAc[10:0], linkAc[12:11]} : {linkAc[11:0], linkAc[12]};
            end else if (group1.rar) begin
              linkAc = group1.bsw ? {linkAc[1:0], linkAc[12:2]} : {linkAc[0], linkAc[12:1]};
            end else if (group1.bsw) begin
              linkAc = {link, ac[5:0], ac[11:6]};
            end
            {linkNext, acNext} = linkAc;
          end
        endcase
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ac <= '0;
      link <= 1'b0;
    end else begin
      ac <= acNext;
      link <= linkNext;
    end
  end

  assert property (@(posedge clk) disable iff (!rstN)
    (alu.op == pdp8Pkg::aluGroup1Step) |-> !(group1.ral && group1.rar));

endmodule

// ==== hdl/pdp8Memory.sv ====
// PDP-8 core memory
// Word array with registered read, shared by the processor
// and the host port, host owns it while the core is stopped

`timescale 1ns/10ps

module pdp8Memory #(
  parameter int memAddrBits = 12
) (
  input  logic            clk,
  input  pdp8Pkg::memReq  cpuPort,
  input  pdp8Pkg::memReq  hostPort,
  input  logic            hostSelect,
  output pdp8Pkg::pdpWord rdata
);

  pdp8Pkg::pdpWord mem [2**memAddrBits];
  pdp8Pkg::memReq  sel;

  assign sel = hostSelect ? hostPort : cpuPort;

  always_ff @(posedge clk) begin
    if (sel.we) begin
      mem[sel.addr[memAddrBits-1:0]] <= sel.wdata;
    end
    if (sel.re) begin
      rdata <= mem[sel.addr[memAddrBits-1:0]];
    end
  end

  // Stopped core must not compete with the host
  assert property (@(posedge clk) hostSelect |-> !(cpuPort.re || cpuPort.we));

endmodule

// ==== hdl/pdp8ApbRegs.sv ====
// PDP-8 APB host port
// Control, start-address and status registers plus a memory
// window with one wait state per access

`timescale 1ns/10ps

module pdp8ApbRegs (
  input  logic            clk,
  input  logic            rstN,
  input  pdp8Pkg::apbReq  apbIn,
  output pdp8Pkg::apbRsp  apbOut,
  input  logic            running,
  input  pdp8Pkg::pdpWord ac,
  input  logic            link,
  input  pdp8Pkg::pdpWord memRdata,
  output pdp8Pkg::memReq  hostPort,
  output logic            start,
  output pdp8Pkg::pdpWord startPc
);

  logic access;
  logic isMem;
  logic isCtrl;
  logic isStart;
  logic isStatus;
  logic badAddr;
  logic memIssue;
  logic memWait;
  logic memBlocked;

  assign access = apbIn.psel && apbIn.penable;
  assign isMem = apbIn.paddr[pdp8Pkg::memWindowBit];
  assign isCtrl = !isMem && (apbIn.paddr == pdp8Pkg::ctrlAddr);
  assign isStart = !isMem && (apbIn.paddr == pdp8Pkg::startAddr);
  assign isStatus = !isMem && (apbIn.paddr == pdp8Pkg::statusAddr);
  assign badAddr = !isMem && !isCtrl && !isStart && !isStatus;

  // First access cycle of a window transfer talks to memory
  assign memIssue = access && isMem && !memWait;

  assign start = access && apbIn.pwrite && isCtrl && apbIn.pwdata[0] && !running;

  always_comb begin
    hostPort = '0;
    hostPort.addr = apbIn.paddr[13:2];
    hostPort.wdata = apbIn.pwdata[11:0];
    hostPort.we = memIssue && apbIn.pwrite && !running;
    hostPort.re = memIssue && !apbIn.pwrite && !running;
  end

  always_comb begin
    apbOut = '0;
    apbOut.pready = access && !memIssue;
    apbOut.pslverr = apbOut.pready && (badAddr || (isMem && memBlocked));
    if (access && !apbIn.pwrite) begin
      if (isMem) begin
        apbOut.prdata = memBlocked ? 32'd0 : {20'd0, memRdata};
      end else if (isCtrl) begin
        apbOut.prdata = {31'd0, running};
      end else if (isStart) begin
        apbOut.prdata = {20'd0, startPc};
      end else if (isStatus) begin
        apbOut.prdata = {4'd0, ac, 14'd0, link, running};
      end
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      memWait <= 1'b0;
      memBlocked <= 1'b0;
      startPc <= '0;
    end else begin
      memWait <= memIssue;
      if (memIssue) begin
        memBlocked <= running;
      end
      if (access && apbIn.pwrite && isStart) begin
        startPc <= apbIn.pwdata[11:0];
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rstN) apbIn.penable |-> apbIn.psel);

endmodule

// ==== hdl/pdp8Top.sv ====
// PDP-8 core top level
// Sequencer, decoder, AC datapath, memory and APB host port

`timescale 1ns/10ps

module pdp8Top #(
  parameter int memAddrBits = 12
) (
  input  logic           clk,
  input  logic           rstN,
  input  pdp8Pkg::apbReq apbIn,
  output pdp8Pkg::apbRsp apbOut,
  output logic           running
);

  pdp8Pkg::pdpWord      ir;
  pdp8Pkg::pdpWord      pc;
  pdp8Pkg::pdpWord      ac;
  pdp8Pkg::pdpWord      memRdata;
  pdp8Pkg::pdpWord      startPc;
  pdp8Pkg::decodedInstr instr;
  pdp8Pkg::memReq       cpuPort;
  pdp8Pkg::memReq       hostPort;
  pdp8Pkg::aluCmd       alu;
  logic                 link;
  logic                 skipTaken;
  logic                 start;

  pdp8ApbRegs pdp8ApbRegs_i (
    .clk      (clk),
    .rstN     (rstN),
    .apbIn    (apbIn),
    .apbOut   (apbOut),
    .running  (running),
    .ac       (ac),
    .link     (link),
    .memRdata (memRdata),
    .hostPort (hostPort),
    .start    (start),
    .startPc  (startPc)
  );

  pdp8Memory #(
    .memAddrBits (memAddrBits)
  ) pdp8Memory_i (
    .clk        (clk),
    .cpuPort    (cpuPort),
    .hostPort   (hostPort),
    .hostSelect (!running),
    .rdata      (memRdata)
  );

  pdp8Decode pdp8Decode_i (
    .ir    (ir),
    .pc    (pc),
    .instr (instr)
  );

  pdp8Execute pdp8Execute_i (
    .clk       (clk),
    .rstN      (rstN),
    .start     (start),
    .startPc   (startPc),
    .instr     (instr),
    .memRdata  (memRdata),
    .skipTaken (skipTaken),
    .acValue   (ac),
    .ir        (ir),
    .pc        (pc),
    .memPort   (cpuPort),
    .alu       (alu),
    .running   (running)
  );

  pdp8Result pdp8Result_i (
    .clk       (clk),
    .rstN      (rstN),
    .alu       (alu),
    .group1    (instr.group1),
    .group2    (instr.group2),
    .ac        (ac),
    .link      (link),
    .skipTaken (skipTaken)
  );

endmodule

// ==== tests/pdp8Tb.sv ====
// PDP-8 core testbench
// Loads programs through the APB memory window, starts the core
// and checks memory words and the status register after HLT

`timescale 1ns/10ps

module pdp8Tb;

  localparam int halfPeriod = 50;
  localparam int busTimeout = 20;
  localparam int runTimeout = 5000;
  localparam logic [15:0] unmappedAddr = 16'h0010;

  logic            clk;
  logic            rstN;
  pdp8Pkg::apbReq  apbIn;
  pdp8Pkg::apbRsp  apbOut;
  logic            running;
  pdp8Pkg::pdpWord image[$];
  int              seed;

  pdp8Top #(
    .memAddrBits (12)
  ) pdp8Top_i (
    .clk     (clk),
    .rstN    (rstN),
    .apbIn   (apbIn),
    .apbOut  (apbOut),
    .running (running)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #halfPeriod clk = ~clk;
    end
  end

  task automatic abortRun(input string reason);
    $display("TB FAILED");
    $display("%s", reason);
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      abortRun($sformatf("mismatch at %0t: %s expected %h got %h", $time, name, exp, got));
    end
  endtask

  // Memory window never completes in its first access cycle
  assert property (@(posedge clk) disable iff (!rstN)
    ($rose(apbIn.penable) && apbIn.paddr[pdp8Pkg::memWindowBit]) |-> !apbOut.pready)
    else abortRun("APB memory window access completed without its wait state");

  // Core and bus quiet while reset is held
  assert property (@(posedge clk) !rstN |-> (!running && !apbOut.pready && !apbOut.pslverr))
    else abortRun("DUT outputs not idle during reset");

  task automatic transferApb(input logic write, input logic [15:0] addr,
                             input logic [31:0] wdata, output logic [31:0] data,
                             output logic slvErr);
    int waitCycles;
    waitCycles = 0;
    @(negedge clk);
    apbIn.psel = 1'b1;
    apbIn.penable = 1'b0;
    apbIn.pwrite = write;
    apbIn.paddr = addr;
    apbIn.pwdata = wdata;
    @(negedge clk);
    apbIn.penable = 1'b1;
    // pready is looked at halfway through the low phase
    #(halfPeriod / 2);
    while (!apbOut.pready) begin
      waitCycles++;
      if (waitCycles > busTimeout) begin
        abortRun("timeout waiting for pready on an APB transfer");
      end
      @(negedge clk);
      #(halfPeriod / 2);
    end
    data = apbOut.prdata;
    slvErr = apbOut.pslverr;
    @(negedge clk);
    apbIn = '0;
  endtask

  task automatic writeApb(input logic [15:0] addr, input logic [31:0] wdata, input logic expErr);
    logic [31:0] ignored;
    logic        slvErr;
    transferApb(1'b1, addr, wdata, ignored, slvErr);
    checkValue($sformatf("pslverr on write to %h", addr), {31'd0, slvErr}, {31'd0, expErr});
  endtask

  task automatic readApb(input logic [15:0] addr, input logic expErr, output logic [31:0] data);
    logic slvErr;
    transferApb(1'b0, addr, 32'd0, data, slvErr);
    checkValue($sformatf("pslverr on read from %h", addr), {31'd0, slvErr}, {31'd0, expErr});
  endtask

  function automatic logic [15:0] memAddr(input pdp8Pkg::pdpWord idx);
    logic [15:0] addr;
    addr = {2'b00, idx, 2'b00};
    addr[pdp8Pkg::memWindowBit] = 1'b1;
    return addr;
  endfunction

  task automatic writeWord(input pdp8Pkg::pdpWord idx, input pdp8Pkg::pdpWord value);
    writeApb(memAddr(idx), {20'd0, value}, 1'b0);
  endtask

  task automatic checkWord(input pdp8Pkg::pdpWord idx, input pdp8Pkg::pdpWord exp);
    logic [31:0] data;
    readApb(memAddr(idx), 1'b0, data);
    checkValue($sformatf("mem[%o]", idx), data, {20'd0, exp});
  endtask

  task automatic loadImage(input pdp8Pkg::pdpWord base);
    for (int i = 0; i < image.size(); i++) begin
      writeWord(base + pdp8Pkg::pdpWord'(i), image[i]);
    end
  endtask

  task automatic startCore(input pdp8Pkg::pdpWord startPc);
    writeApb(pdp8Pkg::startAddr, {20'd0, startPc}, 1'b0);
    writeApb(pdp8Pkg::ctrlAddr, 32'd1, 1'b0);
    checkValue("running", {31'd0, running}, 32'd1);
  endtask

  task automatic waitIdle();
    int cycles;
    cycles = 0;
    while (running) begin
      cycles++;
      if (cycles > runTimeout) begin
        abortRun("timeout waiting for the core to halt");
      end
      @(negedge clk);
    end
  endtask

  task automatic checkStatus(input pdp8Pkg::pdpWord expAc, input logic expLink);
    logic [31:0] status;
    readApb(pdp8Pkg::statusAddr, 1'b0, status);
    checkValue("status running", {31'd0, status[0]}, 32'd0);
    checkValue("status link", {31'd0, status[1]}, {31'd0, expLink});
    checkValue("status ac", {20'd0, status[27:16]}, {20'd0, expAc});
  endtask

  initial begin
    pdp8Pkg::pdpWord a, b, m, sum, v1, v2, keep;
    pdp8Pkg::pdpWord words[8];
    logic            carry;
    logic [31:0]     data;
    int              n;

    seed = $urandom(42);
    apbIn = '0;
    rstN = 1'b0;
    repeat (4) @(negedge clk);
    rstN = 1'b1;
    @(negedge clk);
    checkValue("running", {31'd0, running}, 32'd0);
    checkValue("pslverr", {31'd0, apbOut.pslverr}, 32'd0);

    // Memory window round trip at scattered addresses
    for (int i = 0; i < 8; i++) begin
      words[i] = pdp8Pkg::pdpWord'($urandom);
      writeWord(pdp8Pkg::pdpWord'(i * 'o421), words[i]);
    end
    for (int i = 0; i < 8; i++) begin
      checkWord(pdp8Pkg::pdpWord'(i * 'o421), words[i]);
    end
    readApb(unmappedAddr, 1'b1, data);
    writeApb(unmappedAddr, 32'd5, 1'b1);

    // TAD A, TAD B, AND M, DCA R on page 1
    a = pdp8Pkg::pdpWord'($urandom);
    b = pdp8Pkg::pdpWord'($urandom);
    m = pdp8Pkg::pdpWord'($urandom);
    {carry, sum} = {1'b0, a} + {1'b0, b};
    image = {12'o7300, 12'o1220, 12'o1221, 12'o0222, 12'o3223, 12'o7402};
    loadImage(12'o0200);
    image = {a, b, m, 12'o7777};
    loadImage(12'o0220);
    startCore(12'o0200);
    waitIdle();
    checkWord(12'o0223, sum & m);
    checkStatus(12'o0000, carry);

    // ISZ loop from minus N, then JMS and return by JMP I
    n = 1 + int'($urandom % 8);
    image = {12'o7300, 12'o1240, 12'o2241, 12'o5201, 12'o4242, 12'o7402};
    loadImage(12'o0600);
    image = {12'o0001, pdp8Pkg::pdpWord'(-n), 12'o0000, 12'o1240, 12'o5642};
    loadImage(12'o0640);
    startCore(12'o0600);
    waitIdle();
    checkWord(12'o0641, 12'o0000);
    checkWord(12'o0642, 12'o0605);
    checkStatus(pdp8Pkg::pdpWord'(n + 1), 1'b0);

    // Indirect through page zero, current page from page 5
    v1 = pdp8Pkg::pdpWord'($urandom);
    v2 = pdp8Pkg::pdpWord'($urandom);
    image = {12'o7300, 12'o1420, 12'o3252, 12'o1251, 12'o3253, 12'o7402};
    loadImage(12'o1200);
    image = {v1, v2, ~v1, ~v2};
    loadImage(12'o1250);
    writeWord(12'o0020, 12'o1250);
    // Same offset on page zero holds a decoy
    writeWord(12'o0051, ~v2);
    startCore(12'o1200);
    waitIdle();
    checkWord(12'o1252, v1);
    checkWord(12'o1253, v2);

    // CLA CLL CMA IAC, RAL of the link, SZA and SNL both ways
    image = {12'o7341, 12'o3240, 12'o7004, 12'o3241, 12'o7440, 12'o1242, 12'o7420, 12'o1243,
             12'o7440, 12'o1244, 12'o7120, 12'o7420, 12'o1245, 12'o3246, 12'o7402};
    loadImage(12'o1400);
    image = {12'o7777, 12'o7777, 12'o0001, 12'o0002, 12'o0004, 12'o0010, 12'o7777};
    loadImage(12'o1440);
    startCore(12'o1400);
    waitIdle();
    checkWord(12'o1440, 12'o0000);
    checkWord(12'o1441, 12'o0001);
    checkWord(12'o1446, 12'o0006);

    // Host memory access while the core runs a long ISZ loop
    keep = pdp8Pkg::pdpWord'($urandom);
    image = {12'o2240, 12'o5200, 12'o7402};
    loadImage(12'o1600);
    writeWord(12'o1640, 12'o7700);
    writeWord(12'o1650, keep);
    startCore(12'o1600);
    writeApb(memAddr(12'o1650), {20'd0, ~keep}, 1'b1);
    readApb(memAddr(12'o1650), 1'b1, data);
    checkValue("prdata while running", data, 32'd0);
    waitIdle();
    checkWord(12'o1640, 12'o0000);
    checkWord(12'o1650, keep);

    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== sources.f ====
hdl/pdp8Pkg.sv
hdl/pdp8Decode.sv
hdl/pdp8Execute.sv
hdl/pdp8Result.sv
hdl/pdp8Memory.sv
hdl/pdp8ApbRegs.sv
hdl/pdp8Top.sv
tests/pdp8Tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the PDP-8 testbench with Verilator, pass only on the log message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module pdp8Tb -f sources.f -o pdp8Sim \
  && { ./obj_dir/pdp8Sim > sim.log 2>&1 || true; } \
  && cat sim.log \
  && grep -q "^TB PASSED$" sim.log \
  || { echo "Simulation did not pass"; exit 1; }
